//--- common/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

	// receive line depth in characters
	localparam int line_chars = 14;

	localparam logic [7:0] char_cr = 8'h0D;

	// ping answer text, first character in the top byte
	localparam logic [31:0] resp_ping_chars = "resp";

	// response lengths including the closing carriage return
	localparam int hex_resp_chars  = 9;
	localparam int ping_resp_chars = 5;

	// wide enough for any response byte index
	localparam int byte_idx_width = 4;

	typedef enum logic [1:0]
	{
		cmd_none,
		cmd_ping,
		cmd_voltage,
		cmd_memory
	} cmd_t;

	typedef enum logic [1:0]
	{
		s_idle,
		s_load,
		s_send
	} seq_state_t;

	function automatic logic [byte_idx_width-1:0] response_length(input cmd_t op);
		logic [byte_idx_width-1:0] len;
		case (op)
			cmd_ping:    len = byte_idx_width'(ping_resp_chars);
			cmd_voltage: len = byte_idx_width'(hex_resp_chars);
			cmd_memory:  len = byte_idx_width'(hex_resp_chars);
			default:     len = '0;
		endcase
		return len;
	endfunction

endpackage

`default_nettype wire

//--- common/sample_pkg.sv
`default_nettype none

package sample_pkg;

	// adc channels served by the voltage command
	localparam int n_channels = 4;

	localparam int sample_width = 32;

	// one hex character per nibble
	localparam int hex_digits = sample_width / 4;

	localparam int channel_idx_width = $clog2(n_channels);

endpackage

`default_nettype wire

//--- design/command_rx/line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module line_buffer
	import cmd_pkg::*;
(
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic [7:0]               rx_byte,
	input  wire logic                     rx_valid,
	output      logic [line_chars*8-1:0]  line,
	output      logic                     line_done
);

	logic [1:0] rx_valid_reg;
	logic [7:0] rx_byte_reg;
	logic       rx_rise;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_valid_reg <= 2'b00;
			rx_byte_reg  <= 8'h00;
		end
		else
		begin
			rx_valid_reg <= {rx_valid_reg[0], rx_valid};
			rx_byte_reg  <= rx_byte;
		end
	end

	assign rx_rise = rx_valid_reg[0] && !rx_valid_reg[1];

	// newest character lands in the low byte, never cleared
	always_ff @(posedge clock)
	begin
		if (rx_rise && (rx_byte_reg != char_cr))
		begin
			line <= {line[(line_chars-1)*8-1:0], rx_byte_reg};
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			line_done <= 1'b0;
		else
			line_done <= rx_rise && (rx_byte_reg == char_cr);
	end

endmodule

`default_nettype wire

//--- design/command_rx/command_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module command_decoder
	import cmd_pkg::*;
	import sample_pkg::*;
(
	input  wire logic [line_chars*8-1:0]      line,
	output      cmd_t                         opcode,
	output      logic [channel_idx_width-1:0] channel,
	output      logic [sample_width-1:0]      memory_value
);

	logic [7:0] last_char;
	logic       all_hex;
	logic       is_ping;
	logic       is_voltage;
	logic       is_memory;

	// {valid, nibble} for one ascii character
	function automatic logic [4:0] hex_decode(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			return {1'b1, 4'(c - 8'h30)};
		else if (c >= "A" && c <= "F")
			return {1'b1, 4'(c - 8'h37)};
		else if (c >= "a" && c <= "f")
			return {1'b1, 4'(c - 8'h57)};
		else
			return 5'b0_0000;
	endfunction

	assign last_char = line[7:0];

	always_comb
	begin
		logic [4:0] dec;
		all_hex = 1'b1;
		memory_value = '0;
		for (int i = 0; i < hex_digits; i++)
		begin
			dec = hex_decode(line[i*8 +: 8]);
			all_hex = all_hex & dec[4];
			memory_value[i*4 +: 4] = dec[3:0];
		end
	end

	assign is_ping    = (line[23:0] == "cmd");
	assign is_voltage = (line[79:8] == "voltagech") && (last_char >= "1") &&
	                    (last_char <= 8'(8'h30 + n_channels));
	assign is_memory  = (line[hex_digits*8 +: 48] == "memory") && all_hex;

	// ascii '1' selects channel index zero
	assign channel = channel_idx_width'(last_char - 8'h31);

	always_comb
	begin
		if (is_ping)
			opcode = cmd_ping;
		else if (is_voltage)
			opcode = cmd_voltage;
		else if (is_memory)
			opcode = cmd_memory;
		else
			opcode = cmd_none;
	end

endmodule

`default_nettype wire

//--- design/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer
	import cmd_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire logic  line_done,
	input  wire cmd_t  opcode,
	input  wire logic  tx_ready,
	input  wire logic  last,
	output      logic  load,
	output      logic  tx_valid,
	output      cmd_t  command
);

	seq_state_t state;
	seq_state_t state_next;

	always_comb
	begin
		state_next = state;
		case (state)
			s_idle:
			begin
				if (line_done && (opcode != cmd_none))
				begin
					state_next = s_load;
				end
			end
			s_load:
			begin
				state_next = s_send;
			end
			s_send:
			begin
				// response ends on the transfer of its final byte
				if (tx_ready && last)
				begin
					state_next = s_idle;
				end
			end
			default:
			begin
				state_next = s_idle;
			end
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= s_idle;
		end
		else
		begin
			state <= state_next;
		end
	end

	// every finished line is reported, busy or not
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			command <= cmd_none;
		end
		else if (line_done)
		begin
			command <= opcode;
		end
	end

	assign load     = (state == s_load);
	assign tx_valid = (state == s_send);

endmodule

`default_nettype wire

//--- design/response_counter.sv
`timescale 1ns/10ps
`default_nettype none

module response_counter
	import cmd_pkg::*;
(
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       load,
	input  wire cmd_t                       opcode,
	input  wire logic                       tx_valid,
	input  wire logic                       tx_ready,
	output      logic [byte_idx_width-1:0]  byte_index,
	output      logic                       last
);

	logic [byte_idx_width-1:0] final_index;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			byte_index  <= '0;
			final_index <= '0;
		end
		else if (load)
		begin
			byte_index  <= '0;
			final_index <= response_length(opcode) - 1'b1;
		end
		else if (tx_valid && tx_ready && !last)
		begin
			byte_index <= byte_index + 1'b1;
		end
	end

	assign last = (byte_index == final_index);

endmodule

`default_nettype wire

//--- design/sample_bank.sv
`timescale 1ns/10ps
`default_nettype none

module sample_bank
	import sample_pkg::*;
(
	input  wire logic                                     clock,
	input  wire logic                                     reset,
	input  wire logic [n_channels-1:0][sample_width-1:0]  adc_data,
	input  wire logic [n_channels-1:0]                    adc_ready,
	input  wire logic [channel_idx_width-1:0]             channel,
	output      logic [sample_width-1:0]                  sample
);

	logic [n_channels-1:0][sample_width-1:0] bank;

	genvar k;
	generate
		for (k = 0; k < n_channels; k++)
		begin : g_channel
			// channel k starts out holding its own number
			always_ff @(posedge clock or posedge reset)
			begin
				if (reset)
				begin
					bank[k] <= sample_width'(k + 1);
				end
				else if (adc_ready[k])
				begin
					bank[k] <= adc_data[k];
				end
			end
		end
	endgenerate

	assign sample = bank[channel];

endmodule

`default_nettype wire

//--- design/response_builder.sv
`timescale 1ns/10ps
`default_nettype none

module response_builder
	import cmd_pkg::*;
	import sample_pkg::*;
(
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire logic                       load,
	input  wire cmd_t                       opcode,
	input  wire logic [sample_width-1:0]    sample,
	input  wire logic [sample_width-1:0]    memory_value,
	input  wire logic [byte_idx_width-1:0]  byte_index,
	output      logic [7:0]                 tx_byte
);

	cmd_t                          resp_op;
	logic [sample_width-1:0]       resp_word;
	logic [$clog2(hex_digits)-1:0] digit_pos;
	logic [1:0]                    ping_pos;

	function automatic logic [7:0] hex_char(input logic [3:0] nibble);
		if (nibble < 4'd10)
			return 8'h30 + 8'(nibble);
		else
			return 8'h37 + 8'(nibble);
	endfunction

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			resp_op <= cmd_none;
		end
		else if (load)
		begin
			resp_op <= opcode;
		end
	end

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			resp_word <= (opcode == cmd_memory) ? memory_value : sample;
		end
	end

	// most significant digit goes out first
	assign digit_pos = ($clog2(hex_digits))'(hex_digits - 1 - int'(byte_index));
	assign ping_pos  = 2'(ping_resp_chars - 2 - int'(byte_index));

	always_comb
	begin
		tx_byte = char_cr;
		case (resp_op)
			cmd_ping:
			begin
				if (int'(byte_index) < ping_resp_chars - 1)
					tx_byte = resp_ping_chars[ping_pos*8 +: 8];
			end
			cmd_voltage, cmd_memory:
			begin
				if (int'(byte_index) < hex_digits)
					tx_byte = hex_char(resp_word[digit_pos*4 +: 4]);
			end
			default:
			begin
				tx_byte = char_cr;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/cmd_processor_top.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_processor_top
	import cmd_pkg::*;
	import sample_pkg::*;
(
	input  wire logic                                      clock,
	input  wire logic                                      reset,
	input  wire logic [7:0]                                rx_byte,
	input  wire logic                                      rx_valid,
	input  wire logic [n_channels-1:0][sample_width-1:0]   adc_data,
	input  wire logic [n_channels-1:0]                     adc_ready,
	output      logic [7:0]                                tx_byte,
	output      logic                                      tx_valid,
	output      cmd_t                                      command,
	input  wire logic                                      tx_ready
);

	logic [line_chars*8-1:0]       line;
	logic                          line_done;
	cmd_t                          opcode;
	logic [channel_idx_width-1:0]  channel;
	logic [sample_width-1:0]       memory_value;
	logic [sample_width-1:0]       sample;
	logic                          load;
	logic                          last;
	logic [byte_idx_width-1:0]     byte_index;

	line_buffer u_line_buffer (
		.clock     (clock),
		.reset     (reset),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.line      (line),
		.line_done (line_done)
	);

	command_decoder u_command_decoder (
		.line         (line),
		.opcode       (opcode),
		.channel      (channel),
		.memory_value (memory_value)
	);

	cmd_sequencer u_cmd_sequencer (
		.clock     (clock),
		.reset     (reset),
		.line_done (line_done),
		.opcode    (opcode),
		.tx_ready  (tx_ready),
		.last      (last),
		.load      (load),
		.tx_valid  (tx_valid),
		.command   (command)
	);

	response_counter u_response_counter (
		.clock      (clock),
		.reset      (reset),
		.load       (load),
		.opcode     (opcode),
		.tx_valid   (tx_valid),
		.tx_ready   (tx_ready),
		.byte_index (byte_index),
		.last       (last)
	);

	sample_bank u_sample_bank (
		.clock     (clock),
		.reset     (reset),
		.adc_data  (adc_data),
		.adc_ready (adc_ready),
		.channel   (channel),
		.sample    (sample)
	);

	response_builder u_response_builder (
		.clock        (clock),
		.reset        (reset),
		.load         (load),
		.opcode       (opcode),
		.sample       (sample),
		.memory_value (memory_value),
		.byte_index   (byte_index),
		.tx_byte      (tx_byte)
	);

endmodule

`default_nettype wire

//--- testbench/cmd_processor_props.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_processor_props
	import cmd_pkg::*;
(
	input wire logic       clock,
	input wire logic       reset,
	input wire logic [7:0] tx_byte,
	input wire logic       tx_valid,
	input wire logic       tx_ready,
	input wire logic       last
);

	quiet_in_reset: assert property (@(posedge clock) reset |-> !tx_valid)
		else $error("tx_valid high while reset is asserted");

	// a stalled byte stays on the bus
	hold_when_stalled: assert property (@(posedge clock) disable iff (reset)
		(tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_byte)))
		else $error("tx_byte or tx_valid changed while stalled");

	last_is_cr: assert property (@(posedge clock) disable iff (reset)
		(tx_valid && tx_ready && last) |-> (tx_byte == char_cr))
		else $error("final response byte is not a carriage return");

endmodule

bind cmd_processor_top cmd_processor_props u_props (
	.clock    (clock),
	.reset    (reset),
	.tx_byte  (tx_byte),
	.tx_valid (tx_valid),
	.tx_ready (tx_ready),
	.last     (last)
);

`default_nettype wire

//--- testbench/tb_cmd_processor.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cmd_processor
	import cmd_pkg::*;
	import sample_pkg::*;
;

	localparam int n_lines      = 17;
	localparam int quiet_cycles = 20;
	localparam int line_cycles  = 4 * (line_chars + 1) + 4;
	localparam int resp_limit   = 6 + 16 * hex_resp_chars;
	localparam int cycle_limit  = 10 * (16 + n_lines * (line_cycles + resp_limit + quiet_cycles));

	logic                                  clock;
	logic                                  reset;
	logic [7:0]                            rx_byte;
	logic                                  rx_valid;
	logic [n_channels-1:0][sample_width-1:0] adc_data;
	logic [n_channels-1:0]                 adc_ready;
	logic                                  tx_ready;
	logic [7:0]                            tx_byte;
	logic                                  tx_valid;
	cmd_t                                  command;

	logic                    stall_mode;
	logic [31:0]             rand_state;
	logic [31:0]             ready_state;
	logic [sample_width-1:0] model [n_channels];
	string                   exp_q [$];
	string                   got;
	string                   exp_text;
	string                   test_name;
	int                      errors;
	int                      err_at_start;
	int                      tests_run;
	int                      tests_failed;
	int                      tx_count;
	int                      done_count;
	int                      cycles;

	cmd_processor_top uut (
		.clock     (clock),
		.reset     (reset),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.adc_data  (adc_data),
		.adc_ready (adc_ready),
		.tx_byte   (tx_byte),
		.tx_valid  (tx_valid),
		.command   (command),
		.tx_ready  (tx_ready)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// response text without the closing carriage return
	function automatic string expected_response(input cmd_t op, input logic [31:0] value);
		string digits = "0123456789ABCDEF";
		string s;
		int    nib;
		s = "";
		if (op == cmd_ping)
			s = "resp";
		else
		begin
			for (int i = hex_digits - 1; i >= 0; i--)
			begin
				nib = int'(value[i*4 +: 4]);
				s = {s, digits.substr(nib, nib)};
			end
		end
		return s;
	endfunction

	always @(negedge clock)
	begin
		if (stall_mode)
		begin
			ready_state = lcg_next(ready_state);
			tx_ready <= ready_state[20];
		end
		else
			tx_ready <= 1'b1;
	end

	// collects each response up to its carriage return
	always @(posedge clock)
	begin
		if (!reset && tx_valid && tx_ready)
		begin
			tx_count++;
			if (tx_byte == char_cr)
			begin
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("test %s sent response %s although none was expected",
						test_name, got);
				end
				else
				begin
					exp_text = exp_q.pop_front();
					assert (got == exp_text)
					else
					begin
						errors++;
						$display("ERR %s expected %s actual %s", test_name, exp_text, got);
					end
				end
				got = "";
				done_count++;
			end
			else
				got = $sformatf("%s%c", got, tx_byte);
		end
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("sim failed");
			$finish;
		end
	end

	task automatic send_byte(input logic [7:0] b);
		@(negedge clock);
		rx_byte  = b;
		rx_valid = 1'b1;
		@(negedge clock);
		@(negedge clock);
		rx_valid = 1'b0;
		@(negedge clock);
	endtask

	task automatic send_line(input string text);
		for (int i = 0; i < text.len(); i++)
			send_byte(text[i]);
		send_byte(char_cr);
	endtask

	task automatic start_test(input string name);
		test_name    = name;
		err_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != err_at_start)
		begin
			tests_failed++;
			$display("test %s: failed", test_name);
		end
		else
			$display("test %s: ok", test_name);
	endtask

	task automatic check_command(input cmd_t op);
		assert (command == op)
		else
		begin
			errors++;
			$display("ERR %s expected %s actual %s", test_name, op.name(), command.name());
		end
	endtask

	task automatic run_command(input string text, input cmd_t op, input logic [31:0] value);
		int target;
		int waited;
		target = done_count + 1;
		waited = 0;
		exp_q.push_back(expected_response(op, value));
		send_line(text);
		while (done_count < target && waited < resp_limit)
		begin
			@(negedge clock);
			waited++;
		end
		if (done_count < target)
		begin
			errors++;
			$display("test %s got no complete response to %s in %0d cycles",
				test_name, text, resp_limit);
			exp_q.delete();
		end
		check_command(op);
	endtask

	task automatic check_rejected(input string text);
		int count;
		count = tx_count;
		send_line(text);
		repeat (quiet_cycles) @(negedge clock);
		assert (tx_count == count)
		else
		begin
			errors++;
			$display("ERR %s expected %0d bytes actual %0d bytes for line %s",
				test_name, 0, tx_count - count, text);
		end
		check_command(cmd_none);
	endtask

	task automatic pulse_adc(input int ch, input logic [31:0] value);
		@(negedge clock);
		adc_data[ch]  = value;
		adc_ready[ch] = 1'b1;
		@(negedge clock);
		adc_ready     = '0;
		model[ch]     = value;
	endtask

	initial
	begin
		logic [31:0] value;
		clock = 1'b0;
		reset = 1'b1;
		rx_byte = 8'h00;
		rx_valid = 1'b0;
		adc_data = '0;
		adc_ready = '0;
		tx_ready = 1'b1;
		stall_mode = 1'b0;
		rand_state = 32'd2570;
		ready_state = 32'd2570;
		got = "";
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		tx_count = 0;
		done_count = 0;
		cycles = 0;
		for (int k = 0; k < n_channels; k++)
			model[k] = 32'(k + 1);
		repeat (16) @(negedge clock);
		reset = 1'b0;

		start_test("ping");
		run_command("cmd", cmd_ping, 32'h0);
		end_test();

		start_test("reset_samples");
		for (int k = 0; k < n_channels; k++)
			run_command($sformatf("voltagech%0d", k + 1), cmd_voltage, model[k]);
		end_test();

		start_test("sample_update");
		rand_state = lcg_next(rand_state);
		pulse_adc(1, rand_state);
		rand_state = lcg_next(rand_state);
		pulse_adc(3, rand_state);
		run_command("voltagech2", cmd_voltage, model[1]);
		run_command("voltagech4", cmd_voltage, model[3]);
		run_command("voltagech1", cmd_voltage, model[0]);
		end_test();

		start_test("memory");
		run_command("memory3aC5e9F0", cmd_memory, 32'h3AC5E9F0);
		run_command("memoryDEADbeef", cmd_memory, 32'hDEADBEEF);
		end_test();

		start_test("rejection");
		check_rejected("hello");
		check_rejected("voltagech5");
		check_rejected("memory12G45678");
		end_test();

		start_test("back_pressure");
		stall_mode = 1'b1;
		rand_state = lcg_next(rand_state);
		pulse_adc(2, rand_state);
		run_command("voltagech3", cmd_voltage, model[2]);
		run_command("voltagech2", cmd_voltage, model[1]);
		rand_state = lcg_next(rand_state);
		value = rand_state;
		run_command($sformatf("memory%08h", value), cmd_memory, value);
		run_command("voltagech4", cmd_voltage, model[3]);
		stall_mode = 1'b0;
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
common/cmd_pkg.sv
common/sample_pkg.sv
design/command_rx/line_buffer.sv
design/command_rx/command_decoder.sv
design/cmd_sequencer.sv
design/response_counter.sv
design/sample_bank.sv
design/response_builder.sv
design/cmd_processor_top.sv
testbench/cmd_processor_props.sv
testbench/tb_cmd_processor.sv

//--- Makefile
# Verilator build and run for the command processor testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_processor
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
